/* build.f */
hdl/map_pkg.sv
hdl/bomb_pkg.sv
hdl/map_ram.sv
hdl/map_port_arbiter.sv
hdl/block_clearer.sv
hdl/bomb_ctrl.sv
hdl/bomb_field_top.sv
bench/bomb_field_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the bomb field testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module bomb_field_tb -f build.f \
  && ./obj_dir/Vbomb_field_tb > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "TEST FAILED" "$LOG" && exit 1 || exit 0

/* bench/bomb_field_tb.sv */
`timescale 1ns/1ns

module bomb_field_tb;

  localparam int DRIVE_DLY       = 1;
  localparam int BOMB_CYCLES     = bomb_pkg::FUSE_CYCLES + 12;
  localparam int EXPLODE_TIMEOUT = 4 * BOMB_CYCLES;  // Room for host read stalls
  // Six bombs, two quiet windows, six map sweeps of ~210 and setup writes fit with margin
  localparam int MAX_CYCLES      = 6000;
  localparam logic [31:0] RAND_SEED = 32'h1d97268d;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       game_over;
  logic                       place_bomb;
  logic [map_pkg::ADDR_W-1:0] bomb_addr;
  logic                       host_wr_en;
  logic [map_pkg::ADDR_W-1:0] host_wr_addr;
  logic [map_pkg::TILE_W-1:0] host_wr_data;
  logic                       host_rd_en;
  logic [map_pkg::ADDR_W-1:0] host_rd_addr;
  logic [map_pkg::TILE_W-1:0] host_rd_data;
  logic                       host_rd_valid;
  logic                       busy;
  logic                       explode;

  logic [map_pkg::TILE_W-1:0] model [map_pkg::DEPTH];  // Expected arena contents
  int mismatch_cnt = 0;
  int other_cnt    = 0;
  int cycle_cnt    = 0;

  bomb_field_top UUT (.*);

  always #5 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
    place_bomb = 1'b0;  // Strobes last one cycle
    host_wr_en = 1'b0;
    host_rd_en = 1'b0;
    game_over  = 1'b0;
  endtask

  task automatic write_tile(input int addr, input logic [map_pkg::TILE_W-1:0] val);
    step();
    host_wr_en   = 1'b1;
    host_wr_addr = map_pkg::ADDR_W'(addr);
    host_wr_data = val;
    model[addr]  = val;
  endtask

  task automatic set_cross(input int center, input logic [1:0] up, input logic [1:0] down,
                           input logic [1:0] left, input logic [1:0] right);
    write_tile(center - map_pkg::NUM_COL, up);
    write_tile(center + map_pkg::NUM_COL, down);
    write_tile(center - 1, left);
    write_tile(center + 1, right);
  endtask

  task automatic place(input int addr);
    step();
    place_bomb = 1'b1;
    bomb_addr  = map_pkg::ADDR_W'(addr);
  endtask

  // Blast rule frees the bomb tile and the adjacent blocks and keeps the rest
  task automatic apply_blast(input int center);
    int nb [4];
    nb[0] = center - map_pkg::NUM_COL;
    nb[1] = center + map_pkg::NUM_COL;
    nb[2] = center - 1;
    nb[3] = center + 1;
    model[center] = map_pkg::TILE_FREE;
    foreach (nb[k]) begin
      if (model[nb[k]] == map_pkg::TILE_BLOCK) begin
        model[nb[k]] = map_pkg::TILE_FREE;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Checkers
  // ------------------------------------------------------------
  task automatic check_read(input string name, input int addr);
    assert (host_rd_valid) else begin
      $display("%s: no read valid one cycle after the request for tile %0d", name, addr);
      other_cnt++;
    end
    assert (host_rd_data == model[addr]) else begin
      $display("mismatch %s tile %0d: expected %0d, actual %0d",
               name, addr, model[addr], host_rd_data);
      mismatch_cnt++;
    end
  endtask

  task automatic check_map(input string name);
    for (int i = 0; i <= map_pkg::DEPTH; i++) begin
      step();
      if (i > 0) begin
        check_read(name, i - 1);  // Read issued last cycle
      end
      if (i < map_pkg::DEPTH) begin
        host_rd_en   = 1'b1;
        host_rd_addr = map_pkg::ADDR_W'(i);
      end
    end
  endtask

  task automatic wait_explode(input string name, input bit with_reads);
    int n;
    int rd_tile;
    bit rd_pending;
    bit seen;
    n          = 0;
    rd_tile    = 0;
    rd_pending = 1'b0;
    seen       = 1'b0;
    while (!seen && n < EXPLODE_TIMEOUT) begin
      step();
      if (rd_pending) begin
        check_read(name, rd_tile);
        rd_pending = 1'b0;
      end else begin
        assert (!host_rd_valid) else begin
          $display("%s: read valid high with no read requested the cycle before", name);
          other_cnt++;
        end
      end
      if (n == 0) begin
        assert (busy) else begin
          $display("%s: busy not raised after the bomb was placed", name);
          other_cnt++;
        end
      end
      if (explode) begin
        seen = 1'b1;
      end else if (with_reads && (n % 4 != 3)) begin
        rd_tile      = 6 * map_pkg::NUM_COL + (n % (4 * map_pkg::NUM_COL));  // Rows 6 to 9
        host_rd_en   = 1'b1;
        host_rd_addr = map_pkg::ADDR_W'(rd_tile);
        rd_pending   = 1'b1;
      end
      n++;
    end
    if (rd_pending) begin
      step();
      check_read(name, rd_tile);
    end
    assert (seen) else begin
      $display("%s: timed out after %0d cycles waiting for explode", name, EXPLODE_TIMEOUT);
      other_cnt++;
    end
    assert (!busy) else begin
      $display("%s: busy still high after the blast", name);
      other_cnt++;
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    repeat (cycles) begin
      step();
      assert (!explode) else begin
        $display("%s: explode pulsed with no bomb accepted", name);
        other_cnt++;
      end
      assert (!busy) else begin
        $display("%s: busy high while no bomb should be active", name);
        other_cnt++;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic load_readback();
    int row;
    int col;
    logic [map_pkg::TILE_W-1:0] val;
    assert (!busy && !explode) else begin
      $display("load_readback: busy or explode high after reset");
      other_cnt++;
    end
    for (int a = 0; a < map_pkg::DEPTH; a++) begin
      row = a / map_pkg::NUM_COL;
      col = a % map_pkg::NUM_COL;
      if (row == 0 || row == map_pkg::NUM_ROW - 1 || col == 0 || col == map_pkg::NUM_COL - 1) begin
        val = map_pkg::TILE_WALL;  // Border
      end else begin
        val = 2'($urandom % 3);    // Free, wall or block
      end
      write_tile(a, val);
    end
    check_map("load_readback");
  endtask

  task automatic full_blast();
    set_cross(61, map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK,
              map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK);
    place(61);
    wait_explode("full_blast", 1'b0);
    apply_blast(61);
    check_map("full_blast");
  endtask

  task automatic mixed_neighbors();
    write_tile(105 - 2 * map_pkg::NUM_COL, map_pkg::TILE_BLOCK);  // Two tiles away
    write_tile(103, map_pkg::TILE_BLOCK);
    write_tile(107, map_pkg::TILE_BLOCK);
    set_cross(105, map_pkg::TILE_WALL, map_pkg::TILE_FREE,
              map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK);
    place(105);
    wait_explode("mixed_neighbors", 1'b0);
    apply_blast(105);
    check_map("mixed_neighbors");
  endtask

  task automatic busy_rules();
    logic [map_pkg::TILE_W-1:0] old;
    set_cross(71, map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK,
              map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK);
    set_cross(137, map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK,
              map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK);
    place(71);
    repeat (3) step();
    place(137);  // Must be ignored
    step();
    old          = model[167];
    host_wr_en   = 1'b1;  // Dropped while busy so the model keeps its value
    host_wr_addr = map_pkg::ADDR_W'(167);
    host_wr_data = (old == map_pkg::TILE_BLOCK) ? map_pkg::TILE_FREE : map_pkg::TILE_BLOCK;
    wait_explode("busy_rules", 1'b0);
    apply_blast(71);
    expect_quiet("busy_rules", 2 * BOMB_CYCLES);
    check_map("busy_rules");
  endtask

  task automatic read_contention();
    set_cross(47, map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK,
              map_pkg::TILE_FREE, map_pkg::TILE_BLOCK);
    place(47);
    wait_explode("read_contention", 1'b1);
    apply_blast(47);
    check_map("read_contention");
  endtask

  task automatic abort_fuse();
    set_cross(160, map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK,
              map_pkg::TILE_BLOCK, map_pkg::TILE_BLOCK);
    place(160);
    model[160] = map_pkg::TILE_BOMB;  // Written before the abort
    repeat (5) step();
    assert (busy) else begin
      $display("abort: busy low during the fuse");
      other_cnt++;
    end
    step();
    game_over = 1'b1;
    expect_quiet("abort", 2 * BOMB_CYCLES);
    check_map("abort");
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rst          = 1'b1;
    game_over    = 1'b0;
    place_bomb   = 1'b0;
    bomb_addr    = '0;
    host_wr_en   = 1'b0;
    host_wr_addr = '0;
    host_wr_data = '0;
    host_rd_en   = 1'b0;
    host_rd_addr = '0;
    void'($urandom(RAND_SEED));
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    load_readback();
    full_blast();
    mixed_neighbors();
    busy_rules();
    read_contention();
    abort_fuse();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt + other_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hdl/bomb_field_top.sv */
`timescale 1ns/1ns

module bomb_field_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       game_over,
  input  logic                       place_bomb,
  input  logic [map_pkg::ADDR_W-1:0] bomb_addr,
  input  logic                       host_wr_en,
  input  logic [map_pkg::ADDR_W-1:0] host_wr_addr,
  input  logic [map_pkg::TILE_W-1:0] host_wr_data,
  input  logic                       host_rd_en,
  input  logic [map_pkg::ADDR_W-1:0] host_rd_addr,
  output logic [map_pkg::TILE_W-1:0] host_rd_data,
  output logic                       host_rd_valid,
  output logic                       busy,
  output logic                       explode
);

  // Controller side
  logic                       ctrl_wr_en;
  logic [map_pkg::ADDR_W-1:0] ctrl_wr_addr;
  logic [map_pkg::TILE_W-1:0] ctrl_wr_data;
  logic                       clear_start;
  logic [map_pkg::ADDR_W-1:0] blast_addr;
  logic                       clear_done;

  // Clearer side
  logic                       rd_req;
  logic [map_pkg::ADDR_W-1:0] clr_rd_addr;
  logic                       read_granted;
  logic                       clr_rd_valid;
  logic [map_pkg::TILE_W-1:0] clr_rd_data;
  logic                       clr_wr_en;
  logic [map_pkg::ADDR_W-1:0] clr_wr_addr;

  // RAM side
  logic                       we;
  logic [map_pkg::ADDR_W-1:0] wr_addr;
  logic [map_pkg::TILE_W-1:0] wr_data;
  logic [map_pkg::ADDR_W-1:0] rd_addr;
  logic [map_pkg::TILE_W-1:0] rd_data;

  bomb_ctrl u_bomb_ctrl (.*);

  block_clearer u_block_clearer (.*);

  map_port_arbiter u_map_port_arbiter (.*);

  map_ram u_map_ram (.*);

endmodule

/* hdl/bomb_ctrl.sv */
`timescale 1ns/1ns

module bomb_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       game_over,
  input  logic                       place_bomb,
  input  logic [map_pkg::ADDR_W-1:0] bomb_addr,
  input  logic                       clear_done,
  output logic                       ctrl_wr_en,
  output logic [map_pkg::ADDR_W-1:0] ctrl_wr_addr,
  output logic [map_pkg::TILE_W-1:0] ctrl_wr_data,
  output logic                       clear_start,
  output logic [map_pkg::ADDR_W-1:0] blast_addr,
  output logic                       busy,
  output logic                       explode
);

  bomb_pkg::ctrl_state_t           state;
  logic [bomb_pkg::FUSE_W-1:0]     fuse_cnt;
  logic [map_pkg::ADDR_W-1:0]      bomb_addr_q;

  // ------------------------------------------------------------
  // Bomb life cycle
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || game_over) begin
      state    <= bomb_pkg::CTRL_IDLE;
      fuse_cnt <= '0;
      explode  <= 1'b0;
    end else begin
      explode <= 1'b0;  // Single-cycle strobe
      case (state)
        bomb_pkg::CTRL_IDLE: begin
          if (place_bomb) begin
            state <= bomb_pkg::CTRL_PLACE;
          end
        end
        bomb_pkg::CTRL_PLACE: begin
          state    <= bomb_pkg::CTRL_FUSE;
          fuse_cnt <= bomb_pkg::FUSE_W'(bomb_pkg::FUSE_CYCLES - 1);
        end
        bomb_pkg::CTRL_FUSE: begin
          if (fuse_cnt == '0) begin
            state <= bomb_pkg::CTRL_DETONATE;
          end else begin
            fuse_cnt <= fuse_cnt - 1'b1;
          end
        end
        bomb_pkg::CTRL_DETONATE: begin
          state <= bomb_pkg::CTRL_WAIT_CLEAR;
        end
        bomb_pkg::CTRL_WAIT_CLEAR: begin
          if (clear_done) begin
            state   <= bomb_pkg::CTRL_IDLE;
            explode <= 1'b1;
          end
        end
        default: state <= bomb_pkg::CTRL_IDLE;
      endcase
    end
  end

  // Bomb position, captured on acceptance
  always_ff @(posedge clk) begin
    if (state == bomb_pkg::CTRL_IDLE && place_bomb) begin
      bomb_addr_q <= bomb_addr;
    end
  end

  // ------------------------------------------------------------
  // Map writes and clearer kick
  // ------------------------------------------------------------
  assign ctrl_wr_en   = (state == bomb_pkg::CTRL_PLACE) || (state == bomb_pkg::CTRL_DETONATE);
  assign ctrl_wr_addr = bomb_addr_q;
  assign ctrl_wr_data = (state == bomb_pkg::CTRL_PLACE) ? map_pkg::TILE_BOMB
                                                        : map_pkg::TILE_FREE;

  assign clear_start  = (state == bomb_pkg::CTRL_DETONATE);
  assign blast_addr   = bomb_addr_q;

  assign busy         = (state != bomb_pkg::CTRL_IDLE);  // Also locks out host writes

endmodule

/* hdl/block_clearer.sv */
`timescale 1ns/1ns

module block_clearer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       game_over,
  input  logic                       clear_start,
  input  logic [map_pkg::ADDR_W-1:0] blast_addr,
  input  logic                       read_granted,
  input  logic                       clr_rd_valid,
  input  logic [map_pkg::TILE_W-1:0] clr_rd_data,
  output logic                       rd_req,
  output logic [map_pkg::ADDR_W-1:0] clr_rd_addr,
  output logic                       clr_wr_en,
  output logic [map_pkg::ADDR_W-1:0] clr_wr_addr,
  output logic                       clear_done
);

  bomb_pkg::clr_state_t      state;
  logic [map_pkg::ADDR_W-1:0] base_addr;   // Blast center
  map_pkg::dir_t             rd_dir;       // Next read direction
  logic                      rd_done;      // All four reads granted
  map_pkg::dir_t             tag;          // Direction of the read in flight
  logic [1:0]                beat_cnt;     // Data beats received
  logic [3:0]                free_mask;    // One bit per direction
  map_pkg::dir_t             step_dir;     // Write-back direction

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || game_over) begin
      state     <= bomb_pkg::CLR_IDLE;
      rd_dir    <= map_pkg::DIR_UP;
      rd_done   <= 1'b0;
      beat_cnt  <= 2'd0;
      free_mask <= 4'd0;
      step_dir  <= map_pkg::DIR_UP;
    end else begin
      case (state)
        bomb_pkg::CLR_IDLE: begin
          if (clear_start) begin
            state     <= bomb_pkg::CLR_READ;
            rd_dir    <= map_pkg::DIR_UP;
            rd_done   <= 1'b0;
            beat_cnt  <= 2'd0;
            free_mask <= 4'd0;
          end
        end
        bomb_pkg::CLR_READ: begin
          if (read_granted) begin
            if (rd_dir == map_pkg::DIR_RIGHT) begin
              rd_done <= 1'b1;
            end else begin
              rd_dir <= map_pkg::dir_t'(rd_dir + 2'd1);
            end
          end
          if (clr_rd_valid) begin
            if (clr_rd_data == map_pkg::TILE_BLOCK) begin
              free_mask[tag] <= 1'b1;  // Destroyable, free it later
            end
            beat_cnt <= beat_cnt + 2'd1;
            if (beat_cnt == 2'd3) begin  // Last of four beats
              state    <= bomb_pkg::CLR_CLEAR;
              step_dir <= map_pkg::DIR_UP;
            end
          end
        end
        bomb_pkg::CLR_CLEAR: begin
          if (step_dir == map_pkg::DIR_RIGHT) begin
            state <= bomb_pkg::CLR_IDLE;
          end else begin
            step_dir <= map_pkg::dir_t'(step_dir + 2'd1);
          end
        end
        default: state <= bomb_pkg::CLR_IDLE;
      endcase
    end
  end

  // Center address and read tag
  always_ff @(posedge clk) begin
    if (state == bomb_pkg::CLR_IDLE && clear_start) begin
      base_addr <= blast_addr;
    end
    if (read_granted) begin
      tag <= rd_dir;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  assign rd_req      = (state == bomb_pkg::CLR_READ) && !rd_done;
  assign clr_rd_addr = map_pkg::neighbor_addr(base_addr, rd_dir);

  assign clr_wr_en   = (state == bomb_pkg::CLR_CLEAR) && free_mask[step_dir];
  assign clr_wr_addr = map_pkg::neighbor_addr(base_addr, step_dir);
  assign clear_done  = (state == bomb_pkg::CLR_CLEAR) && (step_dir == map_pkg::DIR_RIGHT);

endmodule

/* hdl/map_port_arbiter.sv */
`timescale 1ns/1ns

module map_port_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       busy,
  input  logic                       host_wr_en,
  input  logic [map_pkg::ADDR_W-1:0] host_wr_addr,
  input  logic [map_pkg::TILE_W-1:0] host_wr_data,
  input  logic                       host_rd_en,
  input  logic [map_pkg::ADDR_W-1:0] host_rd_addr,
  output logic [map_pkg::TILE_W-1:0] host_rd_data,
  output logic                       host_rd_valid,
  input  logic                       ctrl_wr_en,
  input  logic [map_pkg::ADDR_W-1:0] ctrl_wr_addr,
  input  logic [map_pkg::TILE_W-1:0] ctrl_wr_data,
  input  logic                       rd_req,
  input  logic [map_pkg::ADDR_W-1:0] clr_rd_addr,
  output logic                       read_granted,
  output logic                       clr_rd_valid,
  output logic [map_pkg::TILE_W-1:0] clr_rd_data,
  input  logic                       clr_wr_en,
  input  logic [map_pkg::ADDR_W-1:0] clr_wr_addr,
  output logic                       we,
  output logic [map_pkg::ADDR_W-1:0] wr_addr,
  output logic [map_pkg::TILE_W-1:0] wr_data,
  output logic [map_pkg::ADDR_W-1:0] rd_addr,
  input  logic [map_pkg::TILE_W-1:0] rd_data
);

  // ------------------------------------------------------------
  // Read port, host first
  // ------------------------------------------------------------
  assign read_granted = rd_req && !host_rd_en;
  assign rd_addr      = host_rd_en ? host_rd_addr : clr_rd_addr;

  // Remember who owns the data coming back next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      host_rd_valid <= 1'b0;
      clr_rd_valid  <= 1'b0;
    end else begin
      host_rd_valid <= host_rd_en;
      clr_rd_valid  <= read_granted;
    end
  end

  assign host_rd_data = host_rd_valid ? rd_data : map_pkg::TILE_FREE;
  assign clr_rd_data  = clr_rd_valid ? rd_data : map_pkg::TILE_FREE;

  // ------------------------------------------------------------
  // Write port, controller > clearer > host
  // ------------------------------------------------------------
  always_comb begin
    we      = 1'b0;
    wr_addr = host_wr_addr;
    wr_data = host_wr_data;
    if (ctrl_wr_en) begin
      we      = 1'b1;
      wr_addr = ctrl_wr_addr;
      wr_data = ctrl_wr_data;
    end else if (clr_wr_en) begin
      we      = 1'b1;
      wr_addr = clr_wr_addr;
      wr_data = map_pkg::TILE_FREE;  // Clearer only frees tiles
    end else if (host_wr_en && !busy) begin
      we = 1'b1;                     // Host locked out during a bomb
    end
  end

endmodule

/* hdl/map_ram.sv */
`timescale 1ns/1ns

module map_ram (
  input  logic                       clk,
  input  logic                       we,
  input  logic [map_pkg::ADDR_W-1:0] wr_addr,
  input  logic [map_pkg::TILE_W-1:0] wr_data,
  input  logic [map_pkg::ADDR_W-1:0] rd_addr,
  output logic [map_pkg::TILE_W-1:0] rd_data
);

  // One tile per row-major address
  logic [map_pkg::TILE_W-1:0] mem [map_pkg::DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* hdl/bomb_pkg.sv */
package bomb_pkg;

  // Cycles from bomb tile write to detonation
  localparam int FUSE_CYCLES = 20;
  localparam int FUSE_W      = $clog2(FUSE_CYCLES);

  // ------------------------------------------------------------
  // Bomb controller states
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_PLACE,       // Write bomb tile
    CTRL_FUSE,        // Count down
    CTRL_DETONATE,    // Free bomb tile, kick clearer
    CTRL_WAIT_CLEAR
  } ctrl_state_t;

  // ------------------------------------------------------------
  // Block clearer states
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    CLR_IDLE,
    CLR_READ,   // Fetch the four neighbors
    CLR_CLEAR   // Write back free tiles
  } clr_state_t;

endpackage

/* hdl/map_pkg.sv */
package map_pkg;

  // ------------------------------------------------------------
  // Arena geometry
  // ------------------------------------------------------------
  localparam int NUM_ROW = 11;
  localparam int NUM_COL = 19;
  localparam int DEPTH   = NUM_ROW * NUM_COL;  // 209 tiles
  localparam int ADDR_W  = $clog2(DEPTH);      // 8 bits
  localparam int TILE_W  = 2;

  // Tile codes as stored in the map RAM
  typedef enum logic [TILE_W-1:0] {
    TILE_FREE  = 2'd0,
    TILE_WALL  = 2'd1,
    TILE_BLOCK = 2'd2,  // Destroyable
    TILE_BOMB  = 2'd3
  } tile_t;

  // Blast directions, in scan order
  typedef enum logic [1:0] {
    DIR_UP,
    DIR_DOWN,
    DIR_LEFT,
    DIR_RIGHT
  } dir_t;

  // Address of the tile next to addr in direction dir
  function automatic logic [ADDR_W-1:0] neighbor_addr(input logic [ADDR_W-1:0] addr,
                                                       input dir_t dir);
    case (dir)
      DIR_UP:   return addr - ADDR_W'(NUM_COL);
      DIR_DOWN: return addr + ADDR_W'(NUM_COL);
      DIR_LEFT: return addr - ADDR_W'(1);
      default:  return addr + ADDR_W'(1);  // DIR_RIGHT
    endcase
  endfunction

endpackage
